//--- filelist.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/alu_decoder.sv
rtl/main_decoder.sv
rtl/ctrl_pipeline.sv
rtl/decode_stage.sv
tb/decode_stage_checker.sv
tb/decode_stage_tb.sv

//--- rtl/alu_decoder.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module alu_decoder (
    input  logic [5:0]           opcode,
    input  logic [5:0]           funct,
    output logic [`ALU_OP_W-1:0] alu_op
);

    always_comb begin
        case (opcode)
            `OP_RTYPE: begin
                // r-type operation comes from funct
                case (funct)
                    `FN_ADD: alu_op = `ALU_ADD;
                    `FN_SUB: alu_op = `ALU_SUB;
                    `FN_AND: alu_op = `ALU_AND;
                    `FN_OR:  alu_op = `ALU_OR;
                    `FN_SLT: alu_op = `ALU_SLT;
                    // write enable is cleared in the main decoder
                    default: alu_op = `ALU_ADD;
                endcase
            end
            `OP_ADDI: begin
                alu_op = `ALU_ADD;
            end
            `OP_ANDI: begin
                alu_op = `ALU_AND;
            end
            `OP_ORI: begin
                alu_op = `ALU_OR;
            end
            `OP_LUI: begin
                alu_op = `ALU_LUI;
            end
            // address = base + offset
            `OP_LW, `OP_SW: begin
                alu_op = `ALU_ADD;
            end
            // compare by subtraction
            `OP_BEQ: begin
                alu_op = `ALU_SUB;
            end
            default: begin
                alu_op = `ALU_ADD;
            end
        endcase
    end

endmodule

//--- rtl/ctrl_pipeline.sv
`timescale 1ns/10ps

module ctrl_pipeline (
    input  logic              clk,
    input  logic              rst_n,
    input  mips_pkg::ctrl_e_t ctrl_d,
    output mips_pkg::ctrl_e_t ctrl_e,
    output mips_pkg::ctrl_m_t ctrl_m,
    output mips_pkg::ctrl_w_t ctrl_w
);
    import mips_pkg::*;

    // id/ex, full bundle from decode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_e <= '0;
        end else begin
            ctrl_e <= ctrl_d;
        end
    end

    // ex/mem, execute fields dropped here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_m <= '0;
        end else begin
            ctrl_m <= ctrl_e.mem;
        end
    end

    // mem/wb, only the writeback pair survives
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_w <= '0;
        end else begin
            ctrl_w <= ctrl_m.wb;
        end
    end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  mips_pkg::instr_u  instr,
    input  logic              instr_valid,
    output logic              sign_ext,
    output logic [31:0]       imm_ext,
    output logic              branch,
    output mips_pkg::ctrl_e_t ctrl_e,
    output mips_pkg::ctrl_m_t ctrl_m,
    output mips_pkg::ctrl_w_t ctrl_w
);
    import mips_pkg::*;

    // decode-stage bundle, zero on bubbles
    ctrl_e_t ctrl_d;

    main_decoder u_main_decoder (
        .instr       (instr),
        .instr_valid (instr_valid),
        .sign_ext    (sign_ext),
        .imm_ext     (imm_ext),
        .branch      (branch),
        .ctrl_d      (ctrl_d)
    );

    ctrl_pipeline u_ctrl_pipeline (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl_d (ctrl_d),
        .ctrl_e (ctrl_e),
        .ctrl_m (ctrl_m),
        .ctrl_w (ctrl_w)
    );

endmodule

//--- rtl/main_decoder.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module main_decoder (
    input  mips_pkg::instr_u  instr,
    input  logic              instr_valid,
    output logic              sign_ext,
    output logic [31:0]       imm_ext,
    output logic              branch,
    output mips_pkg::ctrl_e_t ctrl_d
);
    import mips_pkg::*;

    logic [5:0]           opcode;
    logic [5:0]           funct;
    logic [15:0]          imm16;
    logic                 is_lui;
    logic [`ALU_OP_W-1:0] alu_op;
    ctrl_e_t              ctrl_raw;

    assign opcode = instr.i.opcode;
    assign funct  = instr.r.funct;
    assign imm16  = instr.i.imm16;

    alu_decoder u_alu_decoder (
        .opcode (opcode),
        .funct  (funct),
        .alu_op (alu_op)
    );

    // logical immediates and lui are unsigned
    assign is_lui   = (opcode == `OP_LUI);
    assign sign_ext = !((opcode == `OP_ANDI) || (opcode == `OP_ORI) || is_lui);
    assign branch   = (opcode == `OP_BEQ);

    always_comb begin
        if (is_lui) begin
            imm_ext = {imm16, 16'h0000};
        end else if (sign_ext) begin
            imm_ext = {{16{imm16[15]}}, imm16};
        end else begin
            imm_ext = {16'h0000, imm16};
        end
    end

    always_comb begin
        ctrl_raw         = '0;
        ctrl_raw.reg_dst = `REG_DST_RD;
        ctrl_raw.alu_op  = alu_op;
        case (opcode)
            `OP_RTYPE: begin
                case (funct)
                    `FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT: begin
                        ctrl_raw.mem.wb.reg_write_en = 1'b1;
                    end
                    default: begin
                        ctrl_raw.mem.wb.reg_write_en = 1'b0;
                    end
                endcase
            end
            `OP_ADDI, `OP_ANDI, `OP_ORI, `OP_LUI: begin
                ctrl_raw.mem.wb.reg_write_en = 1'b1;
                ctrl_raw.reg_dst             = `REG_DST_RT;
                ctrl_raw.alu_imm_sel         = 1'b1;
            end
            `OP_LW: begin
                ctrl_raw.mem.wb.reg_write_en = 1'b1;
                ctrl_raw.mem.wb.mem_to_reg   = 1'b1;
                ctrl_raw.mem.mem_read_en     = 1'b1;
                ctrl_raw.reg_dst             = `REG_DST_RT;
                ctrl_raw.alu_imm_sel         = 1'b1;
            end
            `OP_SW: begin
                ctrl_raw.mem.mem_write_en = 1'b1;
                ctrl_raw.alu_imm_sel      = 1'b1;
            end
            // beq and unknown opcodes keep every enable low
            default: begin
                ctrl_raw.mem.wb.reg_write_en = 1'b0;
            end
        endcase
    end

    // no strobe means a bubble down the pipe
    assign ctrl_d = instr_valid ? ctrl_raw : '0;

endmodule

//--- rtl/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// primary opcodes, instr[31:26]
`define OP_RTYPE 6'b000000
`define OP_ADDI  6'b001000
`define OP_ANDI  6'b001100
`define OP_ORI   6'b001101
`define OP_LUI   6'b001111
`define OP_LW    6'b100011
`define OP_SW    6'b101011
`define OP_BEQ   6'b000100

// r-type funct field, instr[5:0]
`define FN_ADD 6'b100000
`define FN_SUB 6'b100010
`define FN_AND 6'b100100
`define FN_OR  6'b100101
`define FN_SLT 6'b101010

// alu operation codes
`define ALU_OP_W 3
`define ALU_AND  3'b000
`define ALU_OR   3'b001
`define ALU_ADD  3'b010
`define ALU_LUI  3'b100
`define ALU_SUB  3'b110
`define ALU_SLT  3'b111

// writeback destination select
`define REG_DST_RD 2'b00
`define REG_DST_RT 2'b01
`define REG_DST_RA 2'b10

`endif

//--- rtl/mips_pkg.sv
`include "mips_consts.svh"

package mips_pkg;

    // r-type view of the instruction word
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_type_t;

    // i-type view, immediate in the low half
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

    // writeback stage controls
    typedef struct packed {
        logic reg_write_en;
        logic mem_to_reg;
    } ctrl_w_t;

    // memory stage controls plus what writeback needs
    typedef struct packed {
        logic    mem_read_en;
        logic    mem_write_en;
        ctrl_w_t wb;
    } ctrl_m_t;

    // execute stage controls, carries the later stages along
    typedef struct packed {
        logic [1:0]           reg_dst;
        logic                 alu_imm_sel;
        logic [`ALU_OP_W-1:0] alu_op;
        ctrl_m_t              mem;
    } ctrl_e_t;

endpackage

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module decode_stage_tb -Mdir obj_dir
./obj_dir/Vdecode_stage_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Verification failed" sim.log; then
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

//--- tb/decode_stage_checker.sv
`timescale 1ns/10ps

module decode_stage_checker (
    input logic              clk,
    input logic              rst_n,
    input mips_pkg::ctrl_e_t ctrl_e,
    input mips_pkg::ctrl_m_t ctrl_m,
    input mips_pkg::ctrl_w_t ctrl_w
);
    import mips_pkg::*;

    // all stage registers held at zero in reset
    reset_zero: assert property (@(posedge clk)
        !rst_n |-> (ctrl_e == '0 && ctrl_m == '0 && ctrl_w == '0))
        else $error("stage registers not zero while reset is low");

    // ex/mem takes the memory part of id/ex
    mem_forward: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_m == $past(ctrl_e.mem))
        else $error("ctrl_m does not match previous ctrl_e memory part");

    // mem/wb takes the writeback part of ex/mem
    wb_forward: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_w == $past(ctrl_m.wb))
        else $error("ctrl_w does not match previous ctrl_m writeback part");

    // a load and a store never share the memory stage
    mem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl_m.mem_read_en && ctrl_m.mem_write_en))
        else $error("memory read and write enabled together");

endmodule

bind ctrl_pipeline decode_stage_checker u_decode_stage_checker (
    .clk    (clk),
    .rst_n  (rst_n),
    .ctrl_e (ctrl_e),
    .ctrl_m (ctrl_m),
    .ctrl_w (ctrl_w)
);

//--- tb/decode_stage_tb.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module decode_stage_tb;
    import mips_pkg::*;

    localparam int NUM_TESTS      = 26;
    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_TESTS + 3 + 10;

    logic    clk;
    logic    rst_n;
    instr_u  instr;
    logic    instr_valid;
    logic    sign_ext;
    logic    [31:0] imm_ext;
    logic    branch;
    ctrl_e_t ctrl_e;
    ctrl_m_t ctrl_m;
    ctrl_w_t ctrl_w;

    // stimulus table
    string       t_name   [NUM_TESTS];
    logic        t_valid  [NUM_TESTS];
    logic [31:0] t_word   [NUM_TESTS];
    logic        t_sign   [NUM_TESTS];
    logic [31:0] t_imm    [NUM_TESTS];
    logic        t_branch [NUM_TESTS];
    ctrl_e_t     t_ctrl   [NUM_TESTS];
    int          fill_count;

    // expected bundles for the three stages in flight
    ctrl_e_t hist_ctrl [3];
    string   hist_name [3];
    int      cycle_count;

    decode_stage u_decode_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .sign_ext    (sign_ext),
        .imm_ext     (imm_ext),
        .branch      (branch),
        .ctrl_e      (ctrl_e),
        .ctrl_m      (ctrl_m),
        .ctrl_w      (ctrl_w)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    // r-type word with rs=1, rt=2, rd=3
    function logic [31:0] r_word(input logic [5:0] funct);
        r_word = {`OP_RTYPE, 5'd1, 5'd2, 5'd3, 5'd0, funct};
    endfunction

    // i-type word with rs=1, rt=2
    function logic [31:0] i_word(input logic [5:0] op, input logic [15:0] imm);
        i_word = {op, 5'd1, 5'd2, imm};
    endfunction

    function ctrl_e_t make_ctrl(input logic rw, input logic [1:0] dst, input logic imm_sel,
                                input logic m2r, input logic mrd, input logic mwr,
                                input logic [2:0] alu);
        ctrl_e_t c;
        c                     = '0;
        c.reg_dst             = dst;
        c.alu_imm_sel         = imm_sel;
        c.alu_op              = alu;
        c.mem.mem_read_en     = mrd;
        c.mem.mem_write_en    = mwr;
        c.mem.wb.reg_write_en = rw;
        c.mem.wb.mem_to_reg   = m2r;
        make_ctrl             = c;
    endfunction

    task add_entry(input string name, input logic valid, input logic [31:0] word,
                   input logic sgn, input logic [31:0] imm, input logic br, input ctrl_e_t c);
        t_name[fill_count]   = name;
        t_valid[fill_count]  = valid;
        t_word[fill_count]   = word;
        t_sign[fill_count]   = sgn;
        t_imm[fill_count]    = imm;
        t_branch[fill_count] = br;
        t_ctrl[fill_count]   = c;
        fill_count           = fill_count + 1;
    endtask

    task compare_value(input string test_name, input string field,
                       input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED: test %s field %s expected 0x%0h actual 0x%0h",
                     test_name, field, expected, actual);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", field);
        end
    endtask

    task check_pipeline();
        compare_value(hist_name[0], "ctrl_e", {22'b0, hist_ctrl[0]}, {22'b0, ctrl_e});
        compare_value(hist_name[1], "ctrl_m", {28'b0, hist_ctrl[1].mem}, {28'b0, ctrl_m});
        compare_value(hist_name[2], "ctrl_w", {30'b0, hist_ctrl[2].mem.wb}, {30'b0, ctrl_w});
    endtask

    task shift_history(input string name, input ctrl_e_t c);
        hist_ctrl[2] = hist_ctrl[1];
        hist_name[2] = hist_name[1];
        hist_ctrl[1] = hist_ctrl[0];
        hist_name[1] = hist_name[0];
        hist_ctrl[0] = c;
        hist_name[0] = name;
    endtask

    task fill_table();
        add_entry("add", 1'b1, r_word(`FN_ADD), 1'b1, 32'h0000_1820, 1'b0,
                  make_ctrl(1'b1, `REG_DST_RD, 1'b0, 1'b0, 1'b0, 1'b0, `ALU_ADD));
        add_entry("sub", 1'b1, r_word(`FN_SUB), 1'b1, 32'h0000_1822, 1'b0,
                  make_ctrl(1'b1, `REG_DST_RD, 1'b0, 1'b0, 1'b0, 1'b0, `ALU_SUB));
        add_entry("and", 1'b1, r_word(`FN_AND), 1'b1, 32'h0000_1824, 1'b0,
                  make_ctrl(1'b1, `REG_DST_RD, 1'b0, 1'b0, 1'b0, 1'b0, `ALU_AND));
        add_entry("or", 1'b1, r_word(`FN_OR), 1'b1, 32'h0000_1825, 1'b0,
                  make_ctrl(1'b1, `REG_DST_RD, 1'b0, 1'b0, 1'b0, 1'b0, `ALU_OR));
        add_entry("slt", 1'b1, r_word(`FN_SLT), 1'b1, 32'h0000_182A, 1'b0,
                  make_ctrl(1'b1, `REG_DST_RD, 1'b0, 1'b0, 1'b0, 1'b0, `ALU_SLT));
        add_entry("addi_pos", 1'b1, i_word(`OP_ADDI, 16'h0005), 1'b1, 32'h0000_0005, 1'b0,
                  make_ctrl(1'b1, `REG_DST_RT, 1'b1, 1'b0, 1'b0, 1'b0, `ALU_ADD));
        add_entry("addi_neg", 1'b1, i_word(`OP_ADDI, 16'hFFFC), 1'b1, 32'hFFFF_FFFC, 1'b0,
                  make_ctrl(1'b1, `REG_DST_RT, 1'b1, 1'b0, 1'b0, 1'b0, `ALU_ADD));
        add_entry("andi", 1'b1, i_word(`OP_ANDI, 16'h80F0), 1'b0, 32'h0000_80F0, 1'b0,
                  make_ctrl(1'b1, `REG_DST_RT, 1'b1, 1'b0, 1'b0, 1'b0, `ALU_AND));
        add_entry("ori", 1'b1, i_word(`OP_ORI, 16'hFFFF), 1'b0, 32'h0000_FFFF, 1'b0,
                  make_ctrl(1'b1, `REG_DST_RT, 1'b1, 1'b0, 1'b0, 1'b0, `ALU_OR));
        add_entry("lui_low", 1'b1, i_word(`OP_LUI, 16'h1234), 1'b0, 32'h1234_0000, 1'b0,
                  make_ctrl(1'b1, `REG_DST_RT, 1'b1, 1'b0, 1'b0, 1'b0, `ALU_LUI));
        add_entry("lui_high", 1'b1, i_word(`OP_LUI, 16'hABCD), 1'b0, 32'hABCD_0000, 1'b0,
                  make_ctrl(1'b1, `REG_DST_RT, 1'b1, 1'b0, 1'b0, 1'b0, `ALU_LUI));
        add_entry("lw_pos", 1'b1, i_word(`OP_LW, 16'h0010), 1'b1, 32'h0000_0010, 1'b0,
                  make_ctrl(1'b1, `REG_DST_RT, 1'b1, 1'b1, 1'b1, 1'b0, `ALU_ADD));
        add_entry("lw_neg", 1'b1, i_word(`OP_LW, 16'h8000), 1'b1, 32'hFFFF_8000, 1'b0,
                  make_ctrl(1'b1, `REG_DST_RT, 1'b1, 1'b1, 1'b1, 1'b0, `ALU_ADD));
        add_entry("sw_neg", 1'b1, i_word(`OP_SW, 16'hFFF8), 1'b1, 32'hFFFF_FFF8, 1'b0,
                  make_ctrl(1'b0, `REG_DST_RD, 1'b1, 1'b0, 1'b0, 1'b1, `ALU_ADD));
        add_entry("sw_pos", 1'b1, i_word(`OP_SW, 16'h0024), 1'b1, 32'h0000_0024, 1'b0,
                  make_ctrl(1'b0, `REG_DST_RD, 1'b1, 1'b0, 1'b0, 1'b1, `ALU_ADD));
        add_entry("beq_neg", 1'b1, i_word(`OP_BEQ, 16'hFFFE), 1'b1, 32'hFFFF_FFFE, 1'b1,
                  make_ctrl(1'b0, `REG_DST_RD, 1'b0, 1'b0, 1'b0, 1'b0, `ALU_SUB));
        add_entry("beq_pos", 1'b1, i_word(`OP_BEQ, 16'h0003), 1'b1, 32'h0000_0003, 1'b1,
                  make_ctrl(1'b0, `REG_DST_RD, 1'b0, 1'b0, 1'b0, 1'b0, `ALU_SUB));
        // decode outputs follow the word even without the strobe
        add_entry("bubble_lw", 1'b0, i_word(`OP_LW, 16'h0040), 1'b1, 32'h0000_0040, 1'b0,
                  '0);
        add_entry("b2b_lw", 1'b1, i_word(`OP_LW, 16'h0008), 1'b1, 32'h0000_0008, 1'b0,
                  make_ctrl(1'b1, `REG_DST_RT, 1'b1, 1'b1, 1'b1, 1'b0, `ALU_ADD));
        add_entry("b2b_sw", 1'b1, i_word(`OP_SW, 16'h000C), 1'b1, 32'h0000_000C, 1'b0,
                  make_ctrl(1'b0, `REG_DST_RD, 1'b1, 1'b0, 1'b0, 1'b1, `ALU_ADD));
        add_entry("b2b_add", 1'b1, r_word(`FN_ADD), 1'b1, 32'h0000_1820, 1'b0,
                  make_ctrl(1'b1, `REG_DST_RD, 1'b0, 1'b0, 1'b0, 1'b0, `ALU_ADD));
        add_entry("bubble_beq", 1'b0, i_word(`OP_BEQ, 16'hFFF0), 1'b1, 32'hFFFF_FFF0, 1'b1,
                  '0);
        add_entry("unknown_funct", 1'b1, r_word(6'h3F), 1'b1, 32'h0000_183F, 1'b0,
                  make_ctrl(1'b0, `REG_DST_RD, 1'b0, 1'b0, 1'b0, 1'b0, `ALU_ADD));
        add_entry("unknown_op_3f", 1'b1, i_word(6'h3F, 16'h1234), 1'b1, 32'h0000_1234, 1'b0,
                  make_ctrl(1'b0, `REG_DST_RD, 1'b0, 1'b0, 1'b0, 1'b0, `ALU_ADD));
        add_entry("unknown_op_02", 1'b1, i_word(6'h02, 16'h8001), 1'b1, 32'hFFFF_8001, 1'b0,
                  make_ctrl(1'b0, `REG_DST_RD, 1'b0, 1'b0, 1'b0, 1'b0, `ALU_ADD));
        add_entry("bubble_idle", 1'b0, 32'h0000_0000, 1'b1, 32'h0000_0000, 1'b0, '0);
    endtask

    initial begin
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        cycle_count = 0;
        fill_count  = 0;
        for (int k = 0; k < 3; k++) begin
            hist_ctrl[k] = '0;
            hist_name[k] = "post_reset";
        end
        fill_table();
        if (fill_count != NUM_TESTS) begin
            $display("stimulus table holds %0d entries instead of %0d", fill_count, NUM_TESTS);
            $display("Verification failed");
            $fatal(1, "stimulus table size wrong");
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // nothing in flight before the first strobe
        @(negedge clk);
        check_pipeline();

        for (int i = 0; i < NUM_TESTS; i++) begin
            @(posedge clk);
            instr       <= t_word[i];
            instr_valid <= t_valid[i];
            @(negedge clk);
            compare_value(t_name[i], "sign_ext", {31'b0, t_sign[i]}, {31'b0, sign_ext});
            compare_value(t_name[i], "imm_ext", t_imm[i], imm_ext);
            compare_value(t_name[i], "branch", {31'b0, t_branch[i]}, {31'b0, branch});
            check_pipeline();
            shift_history(t_name[i], t_ctrl[i]);
        end

        // drain the last three through the pipe
        for (int j = 0; j < 3; j++) begin
            @(posedge clk);
            instr_valid <= 1'b0;
            @(negedge clk);
            check_pipeline();
            shift_history("drain", '0);
        end

        $display("Verification passed");
        $finish;
    end

endmodule
